//--- Bender.yml
package:
  name: ecc_arith

sources:
  - hdl/ecc_field_pkg.sv
  - hdl/ecc_instr_pkg.sv
  - hdl/ecc_instr_decoder.sv
  - hdl/ecc_montgomery_mult.sv
  - hdl/ecc_add_sub_mod.sv
  - hdl/ecc_fau.sv
  - hdl/ecc_operand_regfile.sv
  - hdl/ecc_arith_top.sv
  - target: test
    files:
      - tb/ecc_arith_tb.sv

//--- hdl/ecc_add_sub_mod.sv
// Modular add or subtract in one registered cycle
// Operands must already be below prime_i for the result to stay below it

module ecc_add_sub_mod
    import ecc_field_pkg::*;
#(
    parameter int REG_SIZE = ecc_field_pkg::REG_SIZE
) (
    input  logic     clk,
    input  logic     reset_n,

    input  logic     add_en_i,
    input  logic     sub_i,
    input  operand_t opa_i,
    input  operand_t opb_i,
    input  operand_t prime_i,

    output operand_t res_o,
    output logic     ready_o
);

    logic [REG_SIZE:0] sum;
    logic [REG_SIZE:0] sum_red;
    logic [REG_SIZE:0] diff;
    operand_t          diff_fix;
    operand_t          add_res;
    operand_t          sub_res;
    operand_t          res_q;
    logic              ready_q;

    // Sum with carry, then try removing p
    assign sum     = {1'b0, opa_i} + {1'b0, opb_i};
    assign sum_red = sum - {1'b0, prime_i};
    // MSB of sum_red set means sum < p
    assign add_res = sum_red[REG_SIZE] ? sum[REG_SIZE-1:0] : sum_red[REG_SIZE-1:0];

    // Difference with borrow, add p back on borrow
    assign diff     = {1'b0, opa_i} - {1'b0, opb_i};
    assign diff_fix = diff[REG_SIZE-1:0] + prime_i;
    assign sub_res  = diff[REG_SIZE] ? diff_fix : diff[REG_SIZE-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= add_en_i;
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (add_en_i) begin
            res_q <= sub_i ? sub_res : add_res;
        end
    end

    assign res_o   = res_q;
    assign ready_o = ready_q;

endmodule

//--- hdl/ecc_arith_top.sv
// Field engine top; prime_i and mu_i must be held while an operation runs
// mu_i = -prime^-1 mod 2^RADIX, prime odd and above 2

module ecc_arith_top
    import ecc_field_pkg::*;
    import ecc_instr_pkg::*;
#(
    parameter int REG_SIZE = ecc_field_pkg::REG_SIZE,
    parameter int RADIX    = ecc_field_pkg::RADIX
) (
    input  logic      clk,
    input  logic      reset_n,

    // Instructions
    input  logic      instr_valid_i,
    input  instr_t    instr_i,

    // Modulus
    input  operand_t  prime_i,
    input  digit_t    mu_i,

    // Host access
    input  logic      load_en_i,
    input  reg_addr_t load_addr_i,
    input  operand_t  load_data_i,
    input  reg_addr_t rd_addr_i,
    output operand_t  rd_data_o,

    // Status
    output logic      busy_o,
    output logic      done_o
);

    logic      add_en;
    logic      sub;
    logic      mult_en;
    reg_addr_t src_a;
    reg_addr_t src_b;
    reg_addr_t dest;
    operand_t  opa;
    operand_t  opb;
    operand_t  res;
    logic      fau_done;

    ecc_instr_decoder i_decoder (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .fau_done_i    (fau_done),
        .add_en_o      (add_en),
        .sub_o         (sub),
        .mult_en_o     (mult_en),
        .src_a_o       (src_a),
        .src_b_o       (src_b),
        .dest_o        (dest),
        .busy_o        (busy_o)
    );

    ecc_fau #(
        .REG_SIZE (REG_SIZE),
        .RADIX    (RADIX)
    ) i_fau (
        .clk       (clk),
        .reset_n   (reset_n),
        .add_en_i  (add_en),
        .sub_i     (sub),
        .mult_en_i (mult_en),
        .prime_i   (prime_i),
        .mult_mu_i (mu_i),
        .opa_i     (opa),
        .opb_i     (opb),
        .res_o     (res),
        .done_o    (fau_done)
    );

    // Write-back lands on the edge after fau_done
    ecc_operand_regfile #(
        .REG_SIZE (REG_SIZE)
    ) i_regfile (
        .clk         (clk),
        .reset_n     (reset_n),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .src_a_i     (src_a),
        .src_b_i     (src_b),
        .opa_o       (opa),
        .opb_o       (opb),
        .wb_en_i     (fau_done),
        .wb_addr_i   (dest),
        .wb_data_i   (res)
    );

    assign done_o = fau_done;

endmodule

//--- hdl/ecc_fau.sv
// Field arithmetic unit, one operation at a time
// Strobes are registered once here, so units see them one cycle after the decoder

module ecc_fau
    import ecc_field_pkg::*;
#(
    parameter int REG_SIZE = ecc_field_pkg::REG_SIZE,
    parameter int RADIX    = ecc_field_pkg::RADIX
) (
    input  logic     clk,
    input  logic     reset_n,

    input  logic     add_en_i,
    input  logic     sub_i,
    input  logic     mult_en_i,
    input  operand_t prime_i,
    input  digit_t   mult_mu_i,
    input  operand_t opa_i,
    input  operand_t opb_i,

    output operand_t res_o,
    output logic     done_o
);

    logic     add_en_q;
    logic     sub_q;
    logic     mult_start_q;
    logic     mult_start_dly_q;
    logic     mult_start_edge;

    operand_t mult_res;
    logic     mult_ready;
    operand_t add_res;
    logic     add_ready;

    //------------------------------
    // Strobe registers
    //------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            add_en_q         <= 1'b0;
            sub_q            <= 1'b0;
            mult_start_q     <= 1'b0;
            mult_start_dly_q <= 1'b0;
        end else begin
            add_en_q         <= add_en_i;
            sub_q            <= sub_i;
            mult_start_q     <= mult_en_i;
            mult_start_dly_q <= mult_start_q;
        end
    end

    // Multiplier starts on the rising edge only
    assign mult_start_edge = mult_start_q & ~mult_start_dly_q;

    //------------------------------
    // Arithmetic units
    //------------------------------
    ecc_montgomery_mult #(
        .REG_SIZE (REG_SIZE),
        .RADIX    (RADIX)
    ) i_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .start_i   (mult_start_edge),
        .opa_i     (opa_i),
        .opb_i     (opb_i),
        .n_i       (prime_i),
        .n_prime_i (mult_mu_i),
        .p_o       (mult_res),
        .ready_o   (mult_ready)
    );

    ecc_add_sub_mod #(
        .REG_SIZE (REG_SIZE)
    ) i_add_sub (
        .clk      (clk),
        .reset_n  (reset_n),
        .add_en_i (add_en_q),
        .sub_i    (sub_q),
        .opa_i    (opa_i),
        .opb_i    (opb_i),
        .prime_i  (prime_i),
        .res_o    (add_res),
        .ready_o  (add_ready)
    );

    // Never both ready, one op in flight
    assign done_o = mult_ready | add_ready;
    assign res_o  = mult_ready ? mult_res : add_res;

endmodule

//--- hdl/ecc_field_pkg.sv
// Field widths for the arithmetic datapath
// operand_t and digit_t follow the defaults here; REG_SIZE and RADIX overrides must match them
// REG_SIZE must be a multiple of RADIX

package ecc_field_pkg;

    //------------------------------
    // Default widths
    //------------------------------

    // Field element width in bits
    localparam int REG_SIZE = 32;

    // Multiplier digit width in bits
    localparam int RADIX = 8;

    // Digits per operand
    localparam int NUM_DIGITS = REG_SIZE / RADIX;

    //------------------------------
    // Datapath types
    //------------------------------

    // One field element, always below the prime when stored
    typedef logic [REG_SIZE-1:0] operand_t;

    // One multiplier digit, also the width of mu
    typedef logic [RADIX-1:0] digit_t;

endpackage

//--- hdl/ecc_instr_decoder.sv
// Accepts one instruction at a time; anything arriving while busy is dropped
// Addresses stay valid from accept until the next accepted instruction

module ecc_instr_decoder
    import ecc_instr_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    input  logic      instr_valid_i,
    input  instr_t    instr_i,
    input  logic      fau_done_i,

    output logic      add_en_o,
    output logic      sub_o,
    output logic      mult_en_o,
    output reg_addr_t src_a_o,
    output reg_addr_t src_b_o,
    output reg_addr_t dest_o,
    output logic      busy_o
);

    opcode_t   opcode;
    logic      accept;
    logic      busy_q;

    // Field split
    assign opcode = opcode_t'(instr_i[OPCODE_MSB:OPCODE_LSB]);

    // Only when idle, NOP ignored
    assign accept = instr_valid_i && !busy_q && (opcode != NOP);

    // Strobes last one cycle after accept
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            add_en_o  <= 1'b0;
            sub_o     <= 1'b0;
            mult_en_o <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            // Adder serves both ADD and SUB, sub selects the mode
            add_en_o  <= accept && ((opcode == ADD) || (opcode == SUB));
            sub_o     <= accept && (opcode == SUB);
            mult_en_o <= accept && (opcode == MUL);
            if (accept) begin
                busy_q <= 1'b1;
            end else if (fau_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Addresses held for the operand reads and write-back
    always_ff @(posedge clk) begin
        if (accept) begin
            dest_o  <= instr_i[DEST_MSB:DEST_LSB];
            src_a_o <= instr_i[SRC_A_MSB:SRC_A_LSB];
            src_b_o <= instr_i[SRC_B_MSB:SRC_B_LSB];
        end
    end

    assign busy_o = busy_q;

endmodule

//--- hdl/ecc_instr_pkg.sv
// Instruction word layout for the field engine
// Word is opcode, destination, source A, source B from MSB down

package ecc_instr_pkg;

    //------------------------------
    // Register file addressing
    //------------------------------

    localparam int REG_ADDR_W = 3;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Operation codes, NOP is never accepted
    typedef enum logic [1:0] {
        NOP = 2'b00,
        ADD = 2'b01,
        SUB = 2'b10,
        MUL = 2'b11
    } opcode_t;

    //------------------------------
    // Instruction word fields
    //------------------------------

    localparam int INSTR_W   = 11;
    localparam int OPCODE_MSB = 10;
    localparam int OPCODE_LSB = 9;
    localparam int DEST_MSB   = 8;
    localparam int DEST_LSB   = 6;
    localparam int SRC_A_MSB  = 5;
    localparam int SRC_A_LSB  = 3;
    localparam int SRC_B_MSB  = 2;
    localparam int SRC_B_LSB  = 0;

    typedef logic [INSTR_W-1:0] instr_t;

endpackage

//--- hdl/ecc_montgomery_mult.sv
// Word-serial Montgomery multiply, p = a * b * 2^-REG_SIZE mod n
// Needs a, b < n, n odd, and n_prime = -n^-1 mod 2^RADIX; result valid while ready_o is high

module ecc_montgomery_mult
    import ecc_field_pkg::*;
#(
    parameter int REG_SIZE = ecc_field_pkg::REG_SIZE,
    parameter int RADIX    = ecc_field_pkg::RADIX
) (
    input  logic     clk,
    input  logic     reset_n,

    input  logic     start_i,
    input  operand_t opa_i,
    input  operand_t opb_i,
    input  operand_t n_i,
    input  digit_t   n_prime_i,

    output operand_t p_o,
    output logic     ready_o
);

    localparam int DIGITS = REG_SIZE / RADIX;
    localparam int CNT_W  = $clog2(DIGITS + 1);
    // Accumulator stays below 2n, plus one digit before the shift
    localparam int ACC_W  = REG_SIZE + RADIX + 1;

    typedef enum logic [1:0] {
        IDLE,
        ITER,
        SUB,
        OUT
    } state_e;

    state_e              state_q;
    logic [CNT_W-1:0]    cnt_q;
    logic                ready_q;

    operand_t            a_q;
    operand_t            b_q;
    operand_t            n_q;
    logic [REG_SIZE:0]   acc_q;
    operand_t            p_q;

    digit_t              a_digit;
    digit_t              q_digit;
    logic [ACC_W-1:0]    t_sum;
    logic [ACC_W-1:0]    t_red;
    logic [REG_SIZE:0]   acc_sub;

    //------------------------------
    // Digit step
    //------------------------------
    assign a_digit = a_q[RADIX-1:0];

    // acc + a_i * B
    assign t_sum = ACC_W'(acc_q) + ACC_W'(a_digit) * ACC_W'(b_q);

    // Multiple of n that clears the low digit
    assign q_digit = t_sum[RADIX-1:0] * n_prime_i;

    // Low digit of t_red is zero here
    assign t_red = t_sum + ACC_W'(q_digit) * ACC_W'(n_q);

    // Final correction, MSB set means acc < n
    assign acc_sub = acc_q - {1'b0, n_q};

    // Control
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (start_i) begin
                        state_q <= ITER;
                    end
                end
                ITER: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(DIGITS - 1)) begin
                        state_q <= SUB;
                    end
                end
                SUB: state_q <= OUT;
                OUT: begin
                    ready_q <= 1'b1;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            a_q   <= opa_i;
            b_q   <= opb_i;
            n_q   <= n_i;
            acc_q <= '0;
        end
        if (state_q == ITER) begin
            acc_q <= t_red[ACC_W-1:RADIX];
            a_q   <= a_q >> RADIX;
        end
        if (state_q == SUB) begin
            p_q <= acc_sub[REG_SIZE] ? acc_q[REG_SIZE-1:0] : acc_sub[REG_SIZE-1:0];
        end
    end

    assign p_o     = p_q;
    assign ready_o = ready_q;

endmodule

//--- hdl/ecc_operand_regfile.sv
// Eight operand registers, cleared by reset
// Write-back beats a host load to the same address; all reads are combinational

module ecc_operand_regfile
    import ecc_field_pkg::*;
    import ecc_instr_pkg::*;
#(
    parameter int REG_SIZE = ecc_field_pkg::REG_SIZE
) (
    input  logic      clk,
    input  logic      reset_n,

    // Host side
    input  logic      load_en_i,
    input  reg_addr_t load_addr_i,
    input  operand_t  load_data_i,
    input  reg_addr_t rd_addr_i,
    output operand_t  rd_data_o,

    // Engine side
    input  reg_addr_t src_a_i,
    input  reg_addr_t src_b_i,
    output operand_t  opa_o,
    output operand_t  opb_o,
    input  logic      wb_en_i,
    input  reg_addr_t wb_addr_i,
    input  operand_t  wb_data_i
);

    logic [REG_SIZE-1:0] regs_q [NUM_REGS];

    //------------------------------
    // Write ports
    //------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (load_en_i) begin
                regs_q[load_addr_i] <= load_data_i;
            end
            // Later assignment wins on an address clash
            if (wb_en_i) begin
                regs_q[wb_addr_i] <= wb_data_i;
            end
        end
    end

    //------------------------------
    // Read ports
    //------------------------------
    assign rd_data_o = regs_q[rd_addr_i];
    assign opa_o     = regs_q[src_a_i];
    assign opb_o     = regs_q[src_b_i];

endmodule

//--- tb/ecc_arith_tb.sv
// Self-checking testbench for the field engine, built for REG_SIZE 32 and RADIX 8 only
// All stimulus operands stay below the prime so the reference rules apply

module ecc_arith_tb
    import ecc_instr_pkg::*;
();

    localparam logic [31:0] PRIME    = 32'hFFFF_FFFB;
    localparam int          NUM_ROWS = 16;
    // Per-row budget plus reset and register sweep
    localparam int          CYCLE_LIMIT = 20 * NUM_ROWS + 100;

    logic        clk;
    logic        reset_n;
    logic        instr_valid_i;
    instr_t      instr_i;
    logic [31:0] prime_i;
    logic [7:0]  mu_i;
    logic        load_en_i;
    reg_addr_t   load_addr_i;
    logic [31:0] load_data_i;
    reg_addr_t   rd_addr_i;
    logic [31:0] rd_data_o;
    logic        busy_o;
    logic        done_o;

    // ------------------------------
    // Stimulus table
    // ------------------------------
    opcode_t     row_op    [NUM_ROWS];
    logic [31:0] row_a     [NUM_ROWS];
    logic [31:0] row_b     [NUM_ROWS];
    reg_addr_t   row_sa    [NUM_ROWS];
    reg_addr_t   row_sb    [NUM_ROWS];
    reg_addr_t   row_dst   [NUM_ROWS];
    logic        row_load  [NUM_ROWS];
    logic        row_probe [NUM_ROWS];
    int          n_rows;

    // Expected register file contents
    logic [31:0] shadow [8];
    logic [31:0] rng_state;
    int          err_count   = 0;
    int          test_count  = 0;
    int          fail_count  = 0;
    int          done_count  = 0;
    int          cycle_count = 0;

    ecc_arith_top #(
        .REG_SIZE (32),
        .RADIX    (8)
    ) UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .prime_i       (prime_i),
        .mu_i          (mu_i),
        .load_en_i     (load_en_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .rd_addr_i     (rd_addr_i),
        .rd_data_o     (rd_data_o),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    always #10 clk = ~clk;

    // One count per cycle with done_o high
    always @(negedge clk) begin
        if (done_o === 1'b1) begin
            done_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Run stopped, tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------
    // Reference functions
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_operand();
        rng_state = xorshift32(rng_state);
        return rng_state % PRIME;
    endfunction

    // Search for p * mu = -1 mod 256
    function automatic logic [7:0] compute_mu(input logic [31:0] p);
        logic [7:0]  mu;
        logic [15:0] prod;
        mu = '0;
        for (int i = 0; i < 256; i++) begin
            prod = p[7:0] * 8'(i);
            if (prod[7:0] == 8'hFF) begin
                mu = 8'(i);
            end
        end
        return mu;
    endfunction

    function automatic logic [31:0] field_model(input opcode_t op, input logic [31:0] a,
                                                input logic [31:0] b);
        logic [63:0] t;
        case (op)
            ADD: begin
                t = {32'd0, a} + b;
                t = (t >= PRIME) ? t - PRIME : t;
            end
            SUB: t = (a >= b) ? {32'd0, a - b} : {32'd0, a} + PRIME - b;
            MUL: begin
                t = ({32'd0, a} * {32'd0, b}) % PRIME;
                // Halve mod p once per bit of R = 2^32
                for (int k = 0; k < 32; k++) begin
                    t = t[0] ? (t + PRIME) >> 1 : t >> 1;
                end
            end
            default: t = '0;
        endcase
        return t[31:0];
    endfunction

    function automatic instr_t make_instr(input opcode_t op, input reg_addr_t dst,
                                          input reg_addr_t sa, input reg_addr_t sb);
        instr_t w;
        w = '0;
        w[OPCODE_MSB:OPCODE_LSB] = op;
        w[DEST_MSB:DEST_LSB]     = dst;
        w[SRC_A_MSB:SRC_A_LSB]   = sa;
        w[SRC_B_MSB:SRC_B_LSB]   = sb;
        return w;
    endfunction

    // ------------------------------
    // Driver tasks
    // ------------------------------
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic read_check(input reg_addr_t addr, input logic [31:0] exp);
        rd_addr_i = addr;
        @(negedge clk);
        check_value($sformatf("rd_data_o[r%0d]", addr), rd_data_o, exp);
        step();
    endtask

    task automatic load_reg(input reg_addr_t addr, input logic [31:0] data);
        load_en_i    = 1'b1;
        load_addr_i  = addr;
        load_data_i  = data;
        step();
        load_en_i    = 1'b0;
        shadow[addr] = data;
    endtask

    task automatic issue(input opcode_t op, input reg_addr_t dst, input reg_addr_t sa,
                         input reg_addr_t sb);
        instr_valid_i = 1'b1;
        instr_i       = make_instr(op, dst, sa, sb);
        step();
        instr_valid_i = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: FAILED", name);
        end
    endtask

    task automatic add_row(input opcode_t op, input logic [31:0] a, input logic [31:0] b,
                           input reg_addr_t sa, input reg_addr_t sb, input reg_addr_t dst,
                           input logic ld, input logic pr);
        row_op[n_rows]    = op;
        row_a[n_rows]     = a;
        row_b[n_rows]     = b;
        row_sa[n_rows]    = sa;
        row_sb[n_rows]    = sb;
        row_dst[n_rows]   = dst;
        row_load[n_rows]  = ld;
        row_probe[n_rows] = pr;
        n_rows++;
    endtask

    task automatic build_table();
        n_rows = 0;
        add_row(ADD, 32'd5, 32'd7, 3'd1, 3'd2, 3'd3, 1'b1, 1'b0);
        add_row(ADD, PRIME - 1, PRIME - 1, 3'd1, 3'd2, 3'd3, 1'b1, 1'b0);
        // Sum equal to p wraps to zero
        add_row(ADD, PRIME - 2, 32'd2, 3'd1, 3'd2, 3'd4, 1'b1, 1'b0);
        add_row(ADD, rand_operand(), rand_operand(), 3'd1, 3'd2, 3'd5, 1'b1, 1'b0);
        add_row(SUB, 32'd100, 32'd100, 3'd1, 3'd2, 3'd3, 1'b1, 1'b0);
        add_row(SUB, 32'd3, 32'd10, 3'd1, 3'd2, 3'd4, 1'b1, 1'b0);
        add_row(SUB, rand_operand(), rand_operand(), 3'd1, 3'd2, 3'd6, 1'b1, 1'b0);
        add_row(MUL, 32'd0, rand_operand(), 3'd1, 3'd2, 3'd3, 1'b1, 1'b0);
        add_row(MUL, 32'd1, 32'd1, 3'd1, 3'd2, 3'd4, 1'b1, 1'b0);
        add_row(MUL, PRIME - 1, PRIME - 1, 3'd1, 3'd2, 3'd5, 1'b1, 1'b0);
        add_row(MUL, 32'h1234_5678, 32'h9ABC_DEF0, 3'd1, 3'd2, 3'd6, 1'b1, 1'b1);
        add_row(MUL, rand_operand(), rand_operand(), 3'd1, 3'd2, 3'd7, 1'b1, 1'b0);
        add_row(ADD, rand_operand(), rand_operand(), 3'd1, 3'd2, 3'd5, 1'b1, 1'b1);
        // Chained rows, sources come from earlier results
        add_row(SUB, '0, '0, 3'd7, 3'd1, 3'd7, 1'b0, 1'b0);
        add_row(MUL, '0, '0, 3'd7, 3'd7, 3'd7, 1'b0, 1'b0);
        add_row(ADD, '0, '0, 3'd7, 3'd5, 3'd3, 1'b0, 1'b0);
    endtask

    task automatic run_row(input int i);
        int          errs_before;
        int          dones_before;
        logic [31:0] exp;
        errs_before  = err_count;
        dones_before = done_count;
        if (row_load[i]) begin
            load_reg(row_sa[i], row_a[i]);
            load_reg(row_sb[i], row_b[i]);
        end
        exp = field_model(row_op[i], shadow[row_sa[i]], shadow[row_sb[i]]);
        issue(row_op[i], row_dst[i], row_sa[i], row_sb[i]);
        if (row_probe[i]) begin
            check_value("busy_o", busy_o, 1'b1);
            // Dropped while busy, r0 must keep its value
            issue(ADD, 3'd0, 3'd1, 3'd2);
        end
        do begin
            @(negedge clk);
        end while (done_o !== 1'b1);
        // Write-back edge
        step();
        shadow[row_dst[i]] = exp;
        while (busy_o !== 1'b0) begin
            step();
        end
        if (row_probe[i]) begin
            // Window for a stray second operation
            repeat (16) step();
        end
        check_value("done_o pulse count", done_count - dones_before, 1);
        read_check(row_dst[i], exp);
        if (row_probe[i]) begin
            read_check(3'd0, shadow[0]);
        end
        report_test($sformatf("test %0d %s r%0d <- r%0d, r%0d = %h", i, row_op[i].name(),
                              row_dst[i], row_sa[i], row_sb[i], exp), errs_before);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int errs;
        clk           = 1'b0;
        reset_n       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        prime_i       = PRIME;
        mu_i          = compute_mu(PRIME);
        load_en_i     = 1'b0;
        load_addr_i   = '0;
        load_data_i   = '0;
        rd_addr_i     = '0;
        rng_state     = 32'd92;
        for (int r = 0; r < 8; r++) begin
            shadow[r] = '0;
        end
        build_table();

        repeat (2) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // Idle outputs and cleared registers
        errs = err_count;
        @(negedge clk);
        check_value("busy_o", busy_o, 1'b0);
        check_value("done_o", done_o, 1'b0);
        step();
        for (int r = 0; r < 8; r++) begin
            read_check(3'(r), 32'd0);
        end
        report_test("reset state", errs);

        errs = err_count;
        load_reg(3'd0, 32'h0BAD_F00D);
        read_check(3'd0, 32'h0BAD_F00D);
        report_test("host load and read", errs);

        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end

        $display("%0d tests, %0d failed, %0d check errors", test_count, fail_count,
                 err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
hdl/ecc_field_pkg.sv
hdl/ecc_instr_pkg.sv
hdl/ecc_instr_decoder.sv
hdl/ecc_montgomery_mult.sv
hdl/ecc_add_sub_mod.sv
hdl/ecc_fau.sv
hdl/ecc_operand_regfile.sv
hdl/ecc_arith_top.sv
tb/ecc_arith_tb.sv
